// File: Makefile
TOOL       = verilator
TOP        = tb_soc_peripherals
DUT_TOP    = soc_peripherals
FLIST      = soc_peripherals.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: apb_gpio.sv
/*
 * 32-pin GPIO with two-flop input synchronizer and rising-edge interrupts.
 * INTSTATUS clears on read; an edge in the same cycle stays set.
 */
`default_nettype none

module apb_gpio import soc_periph_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,

    input  apb_req_t apb_req_i,
    output apb_rsp_t apb_rsp_o,

    input  gpio_t    gpio_i,
    output gpio_t    gpio_o,
    output gpio_t    gpio_dir_o,
    output logic     gpio_event_o
);

    reg_offs_t offs;
    logic      acc_wr;
    logic      acc_rd;

    gpio_t dir_q;
    gpio_t out_q;
    gpio_t inten_q;
    gpio_t status_q;

    gpio_t sync_q;
    gpio_t in_q;
    gpio_t hist_q;
    gpio_t rise;
    logic  event_q;

    assign offs   = apb_req_i.paddr[REG_OFFS_W-1:0];
    assign acc_wr = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
    assign acc_rd = apb_req_i.psel & apb_req_i.penable & ~apb_req_i.pwrite;

    //////////////////////////////
    // Input path
    //////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q <= '0;
            in_q   <= '0;
            hist_q <= '0;
        end else begin
            sync_q <= gpio_i;
            in_q   <= sync_q;
            hist_q <= in_q;
        end
    end

    // Rising edges on enabled pins only
    assign rise = in_q & ~hist_q & inten_q;

    //////////////////////////////
    // Registers
    //////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dir_q   <= '0;
            out_q   <= '0;
            inten_q <= '0;
        end else if (acc_wr) begin
            case (offs)
                GPIO_DIR:   dir_q   <= apb_req_i.pwdata;
                GPIO_OUT:   out_q   <= apb_req_i.pwdata;
                GPIO_INTEN: inten_q <= apb_req_i.pwdata;
                default: ;
            endcase
        end
    end

    // Clear-on-read, new edges are ORed in after the clear
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            status_q <= '0;
            event_q  <= 1'b0;
        end else begin
            if (acc_rd && offs == GPIO_INTSTATUS) begin
                status_q <= rise;
            end else begin
                status_q <= status_q | rise;
            end
            event_q <= |(rise & ~status_q);
        end
    end

    // Read data, valid during the access cycle
    always_comb begin
        apb_rsp_o.pready  = 1'b1;
        apb_rsp_o.pslverr = 1'b0;
        case (offs)
            GPIO_DIR:       apb_rsp_o.prdata = dir_q;
            GPIO_IN:        apb_rsp_o.prdata = in_q;
            GPIO_OUT:       apb_rsp_o.prdata = out_q;
            GPIO_INTEN:     apb_rsp_o.prdata = inten_q;
            GPIO_INTSTATUS: apb_rsp_o.prdata = status_q;
            default:        apb_rsp_o.prdata = '0;
        endcase
    end

    assign gpio_o       = out_q;
    assign gpio_dir_o   = dir_q;
    assign gpio_event_o = event_q;

endmodule

`default_nettype wire

// File: apb_timer_unit.sv
/*
 * One 32-bit up counter with compare, clocked by clk_i or by ref_rise_i.
 * On a match the counter wraps to zero and the event pulses one cycle.
 */
`default_nettype none

module apb_timer_unit import soc_periph_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,

    input  apb_req_t apb_req_i,
    output apb_rsp_t apb_rsp_o,

    input  logic     ref_rise_i,
    output logic     timer_event_o
);

    reg_offs_t offs;
    logic      acc_wr;
    logic      cnt_wr;
    logic      tick;
    logic      match;

    logic      en_q;
    logic      refsrc_q;
    pdata_t    count_q;
    pdata_t    cmp_q;
    logic      event_q;

    assign offs   = apb_req_i.paddr[REG_OFFS_W-1:0];
    assign acc_wr = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
    assign cnt_wr = acc_wr & (offs == TIMER_COUNT);

    // Count source select
    assign tick  = en_q & (refsrc_q ? ref_rise_i : 1'b1);
    assign match = (count_q == cmp_q);

    //////////////////////////////
    // Config and compare
    //////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q     <= 1'b0;
            refsrc_q <= 1'b0;
            cmp_q    <= '0;
        end else if (acc_wr) begin
            if (offs == TIMER_CFG) begin
                en_q     <= apb_req_i.pwdata[TIMER_CFG_EN];
                refsrc_q <= apb_req_i.pwdata[TIMER_CFG_REFSRC];
            end
            if (offs == TIMER_CMP) begin
                cmp_q <= apb_req_i.pwdata;
            end
        end
    end

    //////////////////////////////
    // Counter
    //////////////////////////////
    // A bus write to COUNT takes priority over the increment
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
            event_q <= 1'b0;
        end else begin
            event_q <= tick & match & ~cnt_wr;
            if (cnt_wr) begin
                count_q <= apb_req_i.pwdata;
            end else if (tick) begin
                count_q <= match ? '0 : count_q + 1'b1;
            end
        end
    end

    always_comb begin
        apb_rsp_o.pready  = 1'b1;
        apb_rsp_o.pslverr = 1'b0;
        apb_rsp_o.prdata  = '0;
        case (offs)
            TIMER_CFG: begin
                apb_rsp_o.prdata[TIMER_CFG_EN]     = en_q;
                apb_rsp_o.prdata[TIMER_CFG_REFSRC] = refsrc_q;
            end
            TIMER_COUNT: apb_rsp_o.prdata = count_q;
            TIMER_CMP:   apb_rsp_o.prdata = cmp_q;
            default: ;
        endcase
    end

    assign timer_event_o = event_q;

endmodule

`default_nettype wire

// File: periph_apb_decode.sv
/*
 * Combinational APB split on address bits 11:10.
 * Regions 2 and 3 answer with PSLVERR and zero read data, no wait states.
 */
`default_nettype none

module periph_apb_decode import soc_periph_pkg::*; (
    input  apb_req_t apb_req_i,

    output apb_req_t gpio_req_o,
    input  apb_rsp_t gpio_rsp_i,

    output apb_req_t timer_req_o,
    input  apb_rsp_t timer_rsp_i,

    output apb_rsp_t apb_rsp_o
);

    logic [1:0] region;

    assign region = apb_req_i.paddr[APB_ADDR_W-1:REG_OFFS_W];

    // Forward the request, psel only reaches the addressed slave
    always_comb begin
        gpio_req_o       = apb_req_i;
        gpio_req_o.psel  = apb_req_i.psel & (region == REGION_GPIO);

        timer_req_o      = apb_req_i;
        timer_req_o.psel = apb_req_i.psel & (region == REGION_TIMER);
    end

    //////////////////////////////
    // Response mux
    //////////////////////////////
    always_comb begin
        case (region)
            REGION_GPIO: begin
                apb_rsp_o = gpio_rsp_i;
            end
            REGION_TIMER: begin
                apb_rsp_o = timer_rsp_i;
            end
            default: begin
                // Unmapped, error flagged in the access cycle
                apb_rsp_o.prdata  = '0;
                apb_rsp_o.pready  = 1'b1;
                apb_rsp_o.pslverr = apb_req_i.psel & apb_req_i.penable;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: ref_clk_edge_detect.sv
/*
 * slow_clk_i is sampled as data and must stay stable for several clk_i cycles.
 */
`default_nettype none

module ref_clk_edge_detect (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic slow_clk_i,
    output logic rise_o,
    output logic fall_o
);

    logic sync_q1;
    logic sync_q2;
    logic hist_q;
    logic rise_q;
    logic fall_q;

    // Two-flop synchronizer, then history compare into registered pulses
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
            hist_q  <= 1'b0;
            rise_q  <= 1'b0;
            fall_q  <= 1'b0;
        end else begin
            sync_q1 <= slow_clk_i;
            sync_q2 <= sync_q1;
            hist_q  <= sync_q2;
            rise_q  <= sync_q2 & ~hist_q;
            fall_q  <= ~sync_q2 & hist_q;
        end
    end

    assign rise_o = rise_q;
    assign fall_o = fall_q;

endmodule

`default_nettype wire

// File: soc_periph_pkg.sv
/*
 * Shared widths, APB structs, register map and event positions.
 * Each region decodes a 1 KB window selected by address bits 11:10.
 */
`default_nettype none

package soc_periph_pkg;

    // Bus and pin widths
    localparam int unsigned APB_ADDR_W = 12;
    localparam int unsigned APB_DATA_W = 32;
    localparam int unsigned NGPIO      = 32;
    localparam int unsigned REG_OFFS_W = 10;

    typedef logic [APB_ADDR_W-1:0] paddr_t;
    typedef logic [APB_DATA_W-1:0] pdata_t;
    typedef logic [NGPIO-1:0]      gpio_t;
    typedef logic [31:0]           fc_events_t;
    typedef logic [REG_OFFS_W-1:0] reg_offs_t;

    typedef struct packed {
        paddr_t paddr;
        pdata_t pwdata;
        logic   pwrite;
        logic   psel;
        logic   penable;
    } apb_req_t;

    typedef struct packed {
        pdata_t prdata;
        logic   pready;
        logic   pslverr;
    } apb_rsp_t;

    //////////////////////////////
    // Address map
    //////////////////////////////
    localparam logic [1:0] REGION_GPIO  = 2'd0;
    localparam logic [1:0] REGION_TIMER = 2'd1;

    localparam reg_offs_t GPIO_DIR       = 10'h000;
    localparam reg_offs_t GPIO_IN        = 10'h004;
    localparam reg_offs_t GPIO_OUT       = 10'h008;
    localparam reg_offs_t GPIO_INTEN     = 10'h00C;
    localparam reg_offs_t GPIO_INTSTATUS = 10'h010;

    localparam reg_offs_t TIMER_CFG   = 10'h000;
    localparam reg_offs_t TIMER_COUNT = 10'h004;
    localparam reg_offs_t TIMER_CMP   = 10'h008;

    // Bit positions inside TIMER_CFG
    localparam int unsigned TIMER_CFG_EN     = 0;
    localparam int unsigned TIMER_CFG_REFSRC = 1;

    // Fabric controller event lines, the rest are reserved
    localparam int unsigned EVT_TIMER_LO = 10;
    localparam int unsigned EVT_REF_CLK  = 14;
    localparam int unsigned EVT_GPIO     = 15;

endpackage

`default_nettype wire

// File: soc_peripherals.f
soc_periph_pkg.sv
periph_apb_decode.sv
apb_gpio.sv
apb_timer_unit.sv
ref_clk_edge_detect.sv
soc_peripherals.sv
soc_peripherals_chk.sv
tb_soc_peripherals.sv

// File: soc_peripherals.sv
/*
 * Peripheral subsystem behind one APB slave port: GPIO, timer, ref clock edges.
 * Only bits 10, 14 and 15 of fc_events_o are live, all pulses last one cycle.
 */
`default_nettype none

module soc_peripherals import soc_periph_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  apb_req_t   apb_req_i,
    output apb_rsp_t   apb_rsp_o,

    input  logic       slow_clk_i,

    input  gpio_t      gpio_i,
    output gpio_t      gpio_o,
    output gpio_t      gpio_dir_o,

    output fc_events_t fc_events_o
);

    apb_req_t gpio_req;
    apb_rsp_t gpio_rsp;
    apb_req_t timer_req;
    apb_rsp_t timer_rsp;

    logic gpio_event;
    logic timer_event;
    logic ref_rise;
    logic ref_fall;

    //////////////////////////////
    // Bus split
    //////////////////////////////
    periph_apb_decode i_apb_decode (
        .apb_req_i   ( apb_req_i ),
        .gpio_req_o  ( gpio_req  ),
        .gpio_rsp_i  ( gpio_rsp  ),
        .timer_req_o ( timer_req ),
        .timer_rsp_i ( timer_rsp ),
        .apb_rsp_o   ( apb_rsp_o )
    );

    apb_gpio i_apb_gpio (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .apb_req_i    ( gpio_req   ),
        .apb_rsp_o    ( gpio_rsp   ),
        .gpio_i       ( gpio_i     ),
        .gpio_o       ( gpio_o     ),
        .gpio_dir_o   ( gpio_dir_o ),
        .gpio_event_o ( gpio_event )
    );

    // Rise pulses double as the timer's reference tick
    ref_clk_edge_detect i_ref_clk_edge (
        .clk_i      ( clk_i      ),
        .rst_n_i    ( rst_n_i    ),
        .slow_clk_i ( slow_clk_i ),
        .rise_o     ( ref_rise   ),
        .fall_o     ( ref_fall   )
    );

    apb_timer_unit i_apb_timer_unit (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .apb_req_i     ( timer_req   ),
        .apb_rsp_o     ( timer_rsp   ),
        .ref_rise_i    ( ref_rise    ),
        .timer_event_o ( timer_event )
    );

    //////////////////////////////
    // Event vector
    //////////////////////////////
    always_comb begin
        fc_events_o               = '0;
        fc_events_o[EVT_TIMER_LO] = timer_event;
        fc_events_o[EVT_REF_CLK]  = ref_rise | ref_fall;
        fc_events_o[EVT_GPIO]     = gpio_event;
    end

endmodule

`default_nettype wire

// File: soc_peripherals_chk.sv
/*
 * Bus and event protocol properties, bound into soc_peripherals.
 * The timer property assumes TIMER_CMP is nonzero while the timer runs.
 */
`default_nettype none

module soc_peripherals_chk import soc_periph_pkg::*; (
    input logic       clk_i,
    input logic       rst_n_i,
    input apb_req_t   apb_req_i,
    input apb_rsp_t   apb_rsp_i,
    input fc_events_t fc_events_i
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam fc_events_t LIVE_EVT =
        fc_events_t'((1 << EVT_TIMER_LO) | (1 << EVT_REF_CLK) | (1 << EVT_GPIO));

    int unsigned fail_count = 0;
    logic        access;

    assign access = apb_req_i.psel & apb_req_i.penable;

    //////////////////////////////
    // APB response
    //////////////////////////////
    pready_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        access |-> apb_rsp_i.pready)
        else begin
            $error("PREADY low during an APB access cycle");
            fail_count++;
        end

    // Regions 2 and 3 have the top address bit set
    pslverr_unmapped: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        apb_rsp_i.pslverr |-> apb_req_i.paddr[APB_ADDR_W-1])
        else begin
            $error("PSLVERR raised for a mapped region");
            fail_count++;
        end

    //////////////////////////////
    // Event vector
    //////////////////////////////
    reserved_evt_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (fc_events_i & ~LIVE_EVT) == '0)
        else begin
            $error("Reserved fc_events_o bit is set");
            fail_count++;
        end

    timer_evt_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fc_events_i[EVT_TIMER_LO] |=> !fc_events_i[EVT_TIMER_LO])
        else begin
            $error("Timer event high for two cycles in a row");
            fail_count++;
        end

endmodule

bind soc_peripherals soc_peripherals_chk i_soc_peripherals_chk (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .apb_req_i   ( apb_req_i   ),
    .apb_rsp_i   ( apb_rsp_o   ),
    .fc_events_i ( fc_events_o )
);

`default_nettype wire

// File: tb_soc_peripherals.sv
/*
 * Random register, GPIO, timer and reference clock tests against a local model.
 * Stimulus comes from an xorshift generator with a fixed seed.
 */
`default_nettype none

module tb_soc_peripherals import soc_periph_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int APB_TIMEOUT = 16;
    localparam int TIMER_WINDOW = 200;
    localparam paddr_t MAPPED [5] = '{
        {REGION_GPIO, GPIO_DIR}, {REGION_GPIO, GPIO_OUT}, {REGION_GPIO, GPIO_INTEN},
        {REGION_TIMER, TIMER_CMP}, {REGION_TIMER, TIMER_COUNT}
    };

    logic       clk;
    logic       rst_n;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    logic       slow_clk;
    gpio_t      gpio_in;
    gpio_t      gpio_out;
    gpio_t      gpio_dir;
    fc_events_t fc_events;

    logic [31:0] rng_state = 32'd70172;
    int value_errors = 0;
    int timeout_errors = 0;
    int gpio_pulses = 0;
    int timer_pulses = 0;
    int ref_pulses = 0;
    pdata_t model_reg [5] = '{default: '0};

    soc_peripherals soc_peripherals_i (
        .clk_i       ( clk       ),
        .rst_n_i     ( rst_n     ),
        .apb_req_i   ( apb_req   ),
        .apb_rsp_o   ( apb_rsp   ),
        .slow_clk_i  ( slow_clk  ),
        .gpio_i      ( gpio_in   ),
        .gpio_o      ( gpio_out  ),
        .gpio_dir_o  ( gpio_dir  ),
        .fc_events_o ( fc_events )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Pulse counters for the three live event lines
    always @(posedge clk) begin
        if (rst_n) begin
            if (fc_events[EVT_GPIO]) begin
                gpio_pulses <= gpio_pulses + 1;
            end
            if (fc_events[EVT_TIMER_LO]) begin
                timer_pulses <= timer_pulses + 1;
            end
            if (fc_events[EVT_REF_CLK]) begin
                ref_pulses <= ref_pulses + 1;
            end
        end
    end

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic check_value(input string what, input pdata_t got, input pdata_t exp);
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    //////////////////////////////
    // APB transfers
    //////////////////////////////
    task automatic apb_transfer(input logic wr, input paddr_t addr, input pdata_t wdata,
                                output pdata_t rdata, output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        apb_req.pwrite  <= wr;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(posedge clk);
        while (!apb_rsp.pready && waited < APB_TIMEOUT) begin
            waited++;
            @(posedge clk);
        end
        if (!apb_rsp.pready) begin
            $display("Timeout: no PREADY for address 0x%03h after %0d cycles", addr, waited);
            timeout_errors++;
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic apb_write(input paddr_t addr, input pdata_t data, output logic err);
        pdata_t unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input paddr_t addr, output pdata_t data, output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    initial begin
        logic [31:0] r;
        pdata_t rdata;
        paddr_t addr;
        gpio_t prev;
        gpio_t newbits;
        gpio_t status_m;
        logic err;
        int idx;
        int base;
        int expected;
        int cmp_n;
        int rises;

        rst_n    <= 1'b0;
        apb_req  <= '0;
        slow_clk <= 1'b0;
        gpio_in  <= '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        // Register readback with the timer disabled
        for (int i = 0; i < 20; i++) begin
            r = next_random();
            idx = int'(r % 32'd5);
            model_reg[idx] = next_random();
            apb_write(MAPPED[idx], model_reg[idx], err);
            apb_read(MAPPED[idx], rdata, err);
            check_value("register readback", rdata, model_reg[idx]);
        end
        check_value("gpio_dir_o", gpio_dir, model_reg[0]);
        check_value("gpio_o", gpio_out, model_reg[1]);

        // Unmapped regions 2 and 3
        for (int i = 0; i < 10; i++) begin
            r = next_random();
            addr = {1'b1, r[0], r[11:2]};
            if (r[12]) begin
                apb_write(addr, next_random(), err);
            end else begin
                apb_read(addr, rdata, err);
                check_value("unmapped read data", rdata, '0);
            end
            check_value("unmapped PSLVERR", pdata_t'(err), 32'd1);
        end
        for (int i = 0; i < 5; i++) begin
            apb_read(MAPPED[i], rdata, err);
            check_value("register after unmapped access", rdata, model_reg[i]);
        end

        //////////////////////////////
        // GPIO inputs and interrupts
        //////////////////////////////
        prev = '0;
        status_m = '0;
        expected = 0;
        base = gpio_pulses;
        for (int i = 0; i < 12; i++) begin
            r = next_random();
            @(posedge clk);
            gpio_in <= r;
            newbits = r & ~prev & model_reg[2];
            if ((newbits & ~status_m) != '0) begin
                expected++;
            end
            status_m |= newbits;
            prev = r;
            repeat (4 + int'(r[1:0])) @(posedge clk);
            apb_read({REGION_GPIO, GPIO_IN}, rdata, err);
            check_value("GPIO_IN", rdata, prev);
            if (next_random() & 32'd1) begin
                apb_read({REGION_GPIO, GPIO_INTSTATUS}, rdata, err);
                check_value("GPIO_INTSTATUS", rdata, status_m);
                status_m = '0;
            end
        end
        repeat (4) @(posedge clk);
        apb_read({REGION_GPIO, GPIO_INTSTATUS}, rdata, err);
        check_value("GPIO_INTSTATUS final", rdata, status_m);
        check_value("GPIO event count", pdata_t'(gpio_pulses - base), pdata_t'(expected));

        // Timer counting clk wraps once every CMP+1 cycles
        cmp_n = 1 + int'(next_random() % 32'd15);
        apb_write({REGION_TIMER, TIMER_CMP}, pdata_t'(cmp_n), err);
        apb_write({REGION_TIMER, TIMER_COUNT}, '0, err);
        apb_write({REGION_TIMER, TIMER_CFG}, 32'd1, err);
        base = timer_pulses;
        repeat (TIMER_WINDOW) @(posedge clk);
        expected = TIMER_WINDOW / (cmp_n + 1);
        assert (timer_pulses - base >= expected - 1 && timer_pulses - base <= expected + 1)
        else begin
            $display("FAILED at %0t ns: %0d timer events with CMP %0d, expected %0d +/- 1",
                     $time, timer_pulses - base, cmp_n, expected);
            value_errors++;
        end
        apb_write({REGION_TIMER, TIMER_CFG}, '0, err);

        //////////////////////////////
        // Reference clock
        //////////////////////////////
        cmp_n = 2 + int'(next_random() % 32'd4);
        apb_write({REGION_TIMER, TIMER_CMP}, pdata_t'(cmp_n), err);
        apb_write({REGION_TIMER, TIMER_COUNT}, '0, err);
        apb_write({REGION_TIMER, TIMER_CFG}, 32'd3, err);
        base = ref_pulses;
        rises = 0;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            slow_clk <= ~slow_clk;
            if (i % 2 == 0) begin
                rises++;
            end
            repeat (3 + int'(next_random() % 32'd9)) @(posedge clk);
        end
        repeat (6) @(posedge clk);
        check_value("reference edge count", pdata_t'(ref_pulses - base), 32'd16);
        apb_read({REGION_TIMER, TIMER_COUNT}, rdata, err);
        check_value("COUNT on reference clock", rdata, pdata_t'(rises % (cmp_n + 1)));

        $display("Error counts: %0d value, %0d timeout, %0d assertion", value_errors,
                 timeout_errors, soc_peripherals_i.i_soc_peripherals_chk.fail_count);
        if (value_errors == 0 && timeout_errors == 0 &&
            soc_peripherals_i.i_soc_peripherals_chk.fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
